/* bench/mem_ctrl_model.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl_model (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          corrupt,
	input  logic                                          data_wren,
	input  logic                                          data_rden,
	input  logic [hub_pkg::ADDR_W-1:0]                    data_addr,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_wr,
	output logic                                          mc_wr_rdy,
	output logic                                          mc_rd_valid,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_rd
);

	localparam int LINE_W = hub_pkg::LANE_W * hub_pkg::LINE_LANES;

	// Unwritten lines read as zero
	logic [LINE_W-1:0]          store [logic [hub_pkg::ADDR_W-1:0]];
	logic                       busy;
	logic [hub_pkg::ADDR_W-1:0] rd_addr;
	int                         wait_cnt;
	int                         cmd_errors;
	logic                       next_wr_rdy;
	logic                       next_rd_valid;
	logic [LINE_W-1:0]          next_rd_data;

	// Stored line as the controller returns it with bit 0 flipped when corrupt
	function automatic logic [LINE_W-1:0] peek_line(input logic [hub_pkg::ADDR_W-1:0] addr);
		logic [LINE_W-1:0] line;
		line = store.exists(addr) ? store[addr] : '0;
		if (corrupt)
			line[0] = ~line[0];
		return line;
	endfunction

	//////////////////////////////////////////////////
	// Sample commands mid-cycle and answer after the edge
	//////////////////////////////////////////////////

	initial begin
		mc_wr_rdy    = 1'b0;
		mc_rd_valid  = 1'b0;
		data_rd      = '0;
		busy         = 1'b0;
		wait_cnt     = 0;
		cmd_errors   = 0;
		next_rd_data = '0;
		void'($urandom(32'h8d10));
		forever begin
			@(negedge clk_in);
			next_rd_valid = 1'b0;
			next_wr_rdy   = ($urandom % 4) != 0;
			if (gl_rst) begin
				busy = 1'b0;
			end else begin
				if (mc_rd_valid)
					busy = 1'b0;
				if ((data_wren || data_rden) && (busy || (data_wren && data_rden))) begin
					$display("ERROR: controller command at %0t while another is outstanding",
						$time);
					cmd_errors++;
				end
				if (data_wren)
					store[data_addr] = data_wr;
				if (busy && wait_cnt > 0) begin
					wait_cnt--;
					if (wait_cnt == 0) begin
						next_rd_valid = 1'b1;
						next_rd_data  = peek_line(rd_addr);
					end
				end
				// Read latency of 2 to 6 cycles
				if (data_rden) begin
					busy     = 1'b1;
					rd_addr  = data_addr;
					wait_cnt = 1 + ($urandom % 5);
				end
			end
			@(posedge clk_in);
			#2;
			mc_wr_rdy   = next_wr_rdy;
			mc_rd_valid = next_rd_valid;
			if (next_rd_valid)
				data_rd = next_rd_data;
		end
	end

endmodule

`default_nettype wire

/* bench/soc_mem_hub_testdata.txt */
// Columns: command, field a (hex), field b (hex). R corrupt -, T - error, W addr data,
// C addr expected, F frame_base -, D addr data (write and read back during a frame)
T 0 0
C 8000002 2
C 0000040 0
W 0000040 a5a5c3c3
C 0000040 a5a5c3c3
W 0000041 12345678
C 0000041 12345678
C 0100005 01000050
W 8000000 0100002
C 8000000 0100002
C 8000003 0
C 800abcd 0
W 8000001 1
F 0100002 0
W 8000001 0
D 0000050 5a5a0f0f
C 8000001 0
C 0000050 5a5a0f0f
R 1 0
T 0 1
C 8000002 3
C 0000040 a5a5c3c2
C 8000002 3
R 0 0
T 0 0
C 8000002 2
C 0000041 12345678

/* bench/tb_soc_mem_hub.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_soc_mem_hub;

	localparam int LINE_W       = hub_pkg::LANE_W * hub_pkg::LINE_LANES;
	localparam int HOST_TIMEOUT = 2000;
	localparam int TEST_TIMEOUT = 5000;
	localparam int LINE_TIMEOUT = 200;

	logic                        clk_in;
	logic                        gl_rst;
	logic                        host_req;
	logic                        host_rw;
	logic [hub_pkg::ADDR_W-1:0]  host_addr;
	logic [hub_pkg::LANE_W-1:0]  host_wdata;
	logic                        host_done;
	logic [hub_pkg::LANE_W-1:0]  host_rdata;
	logic                        mc_wr_rdy;
	logic                        mc_rd_valid;
	logic [LINE_W-1:0]           data_rd;
	logic                        data_wren;
	logic                        data_rden;
	logic [hub_pkg::ADDR_W-1:0]  data_addr;
	logic [LINE_W-1:0]           data_wr;
	logic [LINE_W-1:0]           line_data;
	logic                        line_valid;
	logic                        last_line;
	logic                        memory_read_error;
	logic                        test_done;
	logic                        corrupt;

	int                          mismatches;
	int                          failures;
	int                          fd;
	int                          c;
	int                          n;
	logic [31:0]                 arg_a;
	logic [31:0]                 arg_b;
	logic [hub_pkg::ADDR_W-1:0]  frame_base;

	always #10 clk_in = ~clk_in;

	soc_mem_hub i_soc_mem_hub (
		.clk_in            (clk_in),
		.gl_rst            (gl_rst),
		.host_req          (host_req),
		.host_rw           (host_rw),
		.host_addr         (host_addr),
		.host_wdata        (host_wdata),
		.mc_wr_rdy         (mc_wr_rdy),
		.mc_rd_valid       (mc_rd_valid),
		.data_rd           (data_rd),
		.host_done         (host_done),
		.host_rdata        (host_rdata),
		.data_wren         (data_wren),
		.data_rden         (data_rden),
		.data_addr         (data_addr),
		.data_wr           (data_wr),
		.line_data         (line_data),
		.line_valid        (line_valid),
		.last_line         (last_line),
		.memory_read_error (memory_read_error),
		.test_done         (test_done)
	);

	mem_ctrl_model mem_model (
		.clk_in      (clk_in),
		.gl_rst      (gl_rst),
		.corrupt     (corrupt),
		.data_wren   (data_wren),
		.data_rden   (data_rden),
		.data_addr   (data_addr),
		.data_wr     (data_wr),
		.mc_wr_rdy   (mc_wr_rdy),
		.mc_rd_valid (mc_rd_valid),
		.data_rd     (data_rd)
	);

	//////////////////////////////////////////////////
	// Bus tasks
	//////////////////////////////////////////////////

	task automatic apply_reset(input logic corrupt_on);
		@(posedge clk_in);
		#2;
		gl_rst   = 1'b1;
		corrupt  = corrupt_on;
		host_req = 1'b0;
		repeat (7) @(posedge clk_in);
		@(negedge clk_in);
		if ({host_done, line_valid, last_line, memory_read_error, test_done,
				data_wren, data_rden} !== 7'd0) begin
			$display("ERROR: strobe, done or error output not low during reset");
			failures++;
		end
		@(posedge clk_in);
		#2;
		gl_rst = 1'b0;
	endtask

	task automatic check_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	// One host strobe and a wait for done
	task automatic host_access(input logic rw, input logic [hub_pkg::ADDR_W-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		@(posedge clk_in);
		#2;
		host_req   = 1'b1;
		host_rw    = rw;
		host_addr  = addr;
		host_wdata = wdata;
		@(posedge clk_in);
		#2;
		host_req = 1'b0;
		cycles   = 1;
		@(negedge clk_in);
		while (!host_done && cycles < HOST_TIMEOUT) begin
			@(negedge clk_in);
			cycles++;
		end
		rdata = host_rdata;
		if (!host_done) begin
			$display("ERROR: host access to %h got no done within %0d cycles", addr, cycles);
			failures++;
		end else if (addr[hub_pkg::IO_REGION_BIT] && cycles != 1) begin
			$display("ERROR: IO access to %h took %0d cycles instead of 1", addr, cycles);
			failures++;
		end
	endtask

	task automatic wait_test_done(input logic exp_err);
		int cycles;
		cycles = 0;
		@(negedge clk_in);
		while (!test_done && cycles < TEST_TIMEOUT) begin
			@(negedge clk_in);
			cycles++;
		end
		if (!test_done) begin
			$display("ERROR: self-test did not finish within %0d cycles", TEST_TIMEOUT);
			failures++;
		end else if (memory_read_error !== exp_err) begin
			$display("MISMATCH memory_read_error: got %h expected %h", memory_read_error, exp_err);
			mismatches++;
		end
	endtask

	// Check one frame line by line against the model's contents
	task automatic check_frame(input logic [hub_pkg::ADDR_W-1:0] base);
		int                cycles;
		int                frame_len;
		logic [LINE_W-1:0] exp_line;
		frame_len = i_soc_mem_hub.FRAME_LINES;
		for (int i = 0; i < frame_len; i++) begin
			cycles = 0;
			@(negedge clk_in);
			while (!line_valid && cycles < LINE_TIMEOUT) begin
				@(negedge clk_in);
				cycles++;
			end
			if (!line_valid) begin
				$display("ERROR: line %0d of the frame at %h never arrived", i, base);
				failures++;
				break;
			end
			exp_line = mem_model.peek_line(base + hub_pkg::ADDR_W'(i));
			if (line_data !== exp_line) begin
				$display("MISMATCH line_data line %0d: got %h expected %h", i, line_data, exp_line);
				mismatches++;
			end
			if (last_line !== (i == frame_len - 1)) begin
				$display("MISMATCH last_line line %0d: got %h expected %h", i, last_line,
					i == frame_len - 1);
				mismatches++;
			end
		end
	endtask

	task automatic run_command(input int cmd, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] word;
		case (cmd)
			"R": apply_reset(a[0]);
			"T": wait_test_done(b[0]);
			"W": host_access(1'b1, a[hub_pkg::ADDR_W-1:0], b, word);
			"C": begin
				host_access(1'b0, a[hub_pkg::ADDR_W-1:0], '0, word);
				check_word("host_rdata", word, b);
			end
			"F": begin
				frame_base = a[hub_pkg::ADDR_W-1:0];
				check_frame(frame_base);
			end
			// Host write and read while a frame is fetched
			"D": begin
				fork
					check_frame(frame_base);
					begin
						host_access(1'b1, a[hub_pkg::ADDR_W-1:0], b, word);
						host_access(1'b0, a[hub_pkg::ADDR_W-1:0], '0, word);
						check_word("host_rdata", word, b);
					end
				join
			end
			default: begin
				$display("ERROR: unknown command %c in the testdata file", cmd);
				failures++;
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Command loop
	//////////////////////////////////////////////////

	initial begin
		clk_in     = 1'b0;
		gl_rst     = 1'b0;
		host_req   = 1'b0;
		host_rw    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		corrupt    = 1'b0;
		mismatches = 0;
		failures   = 0;
		frame_base = '0;
		apply_reset(1'b0);
		fd = $fopen("bench/soc_mem_hub_testdata.txt", "r");
		if (fd == 0) begin
			$display("ERROR: cannot open the testdata file");
			failures++;
		end else begin
			c = $fgetc(fd);
			while (c != -1 && failures == 0) begin
				if (c == "/") begin
					while (c != "\n" && c != -1)
						c = $fgetc(fd);
				end else if (c > " ") begin
					n = $fscanf(fd, "%h %h", arg_a, arg_b);
					if (n != 2) begin
						$display("ERROR: command %c in the testdata file lacks its fields", c);
						failures++;
					end else begin
						run_command(c, arg_a, arg_b);
					end
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
		$display("Errors: %0d mismatches, %0d other failures, %0d controller overlaps",
			mismatches, failures, mem_model.cmd_errors);
		if (mismatches == 0 && failures == 0 && mem_model.cmd_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* design/display_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

module display_fetch #(
	parameter int FRAME_LINES = 12
) (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          display_on,
	input  logic [hub_pkg::ADDR_W-1:0]                    mem_start,
	input  logic                                          disp_ready,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] rdata,
	output logic                                          disp_valid,
	output logic [hub_pkg::ADDR_W-1:0]                    disp_addr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] line_data,
	output logic                                          line_valid,
	output logic                                          last_line
);

	logic                       active_q;
	logic [hub_pkg::ADDR_W-1:0] base_q;
	logic [hub_pkg::ADDR_W-1:0] idx_q;
	logic                       line_valid_q;
	logic                       last_line_q;
	logic                       frame_end;

	assign frame_end = (idx_q == hub_pkg::ADDR_W'(FRAME_LINES - 1));

	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			active_q     <= 1'b0;
			base_q       <= '0;
			idx_q        <= '0;
			line_valid_q <= 1'b0;
			last_line_q  <= 1'b0;
		end else begin
			line_valid_q <= 1'b0;
			last_line_q  <= 1'b0;
			if (!active_q) begin
				// Frame start, sample the base address
				if (display_on) begin
					active_q <= 1'b1;
					base_q   <= mem_start;
					idx_q    <= '0;
				end
			end else if (disp_ready) begin
				line_valid_q <= 1'b1;
				last_line_q  <= frame_end;
				if (frame_end) begin
					idx_q    <= '0;
					base_q   <= mem_start;
					active_q <= display_on;
				end else begin
					idx_q <= idx_q + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_in) begin
		if (active_q && disp_ready)
			line_data <= rdata;
	end

	assign disp_valid = active_q;
	assign disp_addr  = base_q + idx_q;
	assign line_valid = line_valid_q;
	assign last_line  = last_line_q;

endmodule

`default_nettype wire

/* design/hub_pkg.sv */
`default_nettype none

package hub_pkg;

	//////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////

	localparam int LANE_W     = 32;
	localparam int LINE_LANES = 8;
	localparam int ADDR_W     = 28;

	// Host address bit that selects IO space
	localparam int IO_REGION_BIT = 27;

	// Word offsets inside IO space
	localparam logic [IO_REGION_BIT-1:0] IO_ADDR_MEM_START  = 'd0;
	localparam logic [IO_REGION_BIT-1:0] IO_ADDR_DISPLAY_ON = 'd1;
	localparam logic [IO_REGION_BIT-1:0] IO_ADDR_STATUS     = 'd2;

	//////////////////////////////////////////////////
	// State and port encodings
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		READ_WAIT,
		DONE
	} arb_state_e;

	typedef enum logic [1:0] {
		FILL,
		CHECK,
		FINISHED
	} test_state_e;

	// Highest priority first
	typedef enum logic [1:0] {
		PORT_DISPLAY,
		PORT_HOST,
		PORT_TEST
	} arb_port_e;

endpackage

`default_nettype wire

/* design/io_map.sv */
`timescale 1ns/100ps
`default_nettype none

module io_map (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          host_req,
	input  logic                                          host_rw,
	input  logic [hub_pkg::ADDR_W-1:0]                    host_addr,
	input  logic [hub_pkg::LANE_W-1:0]                    host_wdata,
	input  logic                                          host_ready,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] rdata,
	input  logic                                          memory_read_error,
	input  logic                                          test_done,
	output logic                                          host_done,
	output logic [hub_pkg::LANE_W-1:0]                    host_rdata,
	output logic                                          host_valid,
	output logic                                          host_mem_rw,
	output logic [hub_pkg::ADDR_W-1:0]                    host_mem_addr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] host_mem_wdata,
	output logic [hub_pkg::ADDR_W-1:0]                    mem_start,
	output logic                                          display_on
);

	logic                                  io_sel;
	logic [hub_pkg::IO_REGION_BIT-1:0]     io_offset;
	logic [hub_pkg::LANE_W-1:0]            io_rdata;
	logic                                  valid_q;
	logic                                  done_q;
	logic [hub_pkg::LANE_W-1:0]            rdata_q;

	// Region decoded once, in the request cycle
	assign io_sel    = host_addr[hub_pkg::IO_REGION_BIT];
	assign io_offset = host_addr[hub_pkg::IO_REGION_BIT-1:0];

	always_comb begin
		case (io_offset)
			hub_pkg::IO_ADDR_MEM_START:  io_rdata = hub_pkg::LANE_W'(mem_start);
			hub_pkg::IO_ADDR_DISPLAY_ON: io_rdata = hub_pkg::LANE_W'(display_on);
			hub_pkg::IO_ADDR_STATUS:     io_rdata = {30'd0, test_done, memory_read_error};
			default:                     io_rdata = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Display control registers and handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			mem_start  <= '0;
			display_on <= 1'b0;
			valid_q    <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (host_req && io_sel) begin
				done_q <= 1'b1;
				if (host_rw && io_offset == hub_pkg::IO_ADDR_MEM_START)
					mem_start <= host_wdata[hub_pkg::ADDR_W-1:0];
				if (host_rw && io_offset == hub_pkg::IO_ADDR_DISPLAY_ON)
					display_on <= host_wdata[0];
			end else if (host_req) begin
				valid_q <= 1'b1;
			end
			if (host_ready) begin
				valid_q <= 1'b0;
				done_q  <= 1'b1;
			end
		end
	end

	// Memory command and read word, lane 0 only
	always_ff @(posedge clk_in) begin
		if (host_req && !io_sel) begin
			host_mem_rw    <= host_rw;
			host_mem_addr  <= host_addr;
			host_mem_wdata <= {{(hub_pkg::LINE_LANES-1)*hub_pkg::LANE_W{1'b0}}, host_wdata};
		end
		if (host_req && io_sel)
			rdata_q <= io_rdata;
		else if (host_ready)
			rdata_q <= rdata[hub_pkg::LANE_W-1:0];
	end

	assign host_valid = valid_q;
	assign host_done  = done_q;
	assign host_rdata = rdata_q;

endmodule

`default_nettype wire

/* design/mem_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          disp_valid,
	input  logic [hub_pkg::ADDR_W-1:0]                    disp_addr,
	input  logic                                          host_valid,
	input  logic                                          host_rw,
	input  logic [hub_pkg::ADDR_W-1:0]                    host_addr,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] host_wdata,
	input  logic                                          test_valid,
	input  logic                                          test_rw,
	input  logic [hub_pkg::ADDR_W-1:0]                    test_addr,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] test_wdata,
	input  logic                                          mc_wr_rdy,
	input  logic                                          mc_rd_valid,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_rd,
	output logic                                          disp_ready,
	output logic                                          host_ready,
	output logic                                          test_ready,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] rdata,
	output logic                                          data_wren,
	output logic                                          data_rden,
	output logic [hub_pkg::ADDR_W-1:0]                    data_addr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_wr
);

	localparam int LINE_W = hub_pkg::LANE_W * hub_pkg::LINE_LANES;

	hub_pkg::arb_state_e       state_q;
	hub_pkg::arb_port_e        grant_q;
	logic                      rden_q;
	logic [hub_pkg::ADDR_W-1:0] addr_q;
	logic [LINE_W-1:0]         wdata_q;
	logic [LINE_W-1:0]         rdata_q;

	logic                      pick_valid;
	hub_pkg::arb_port_e        pick_port;
	logic                      pick_rw;
	logic [hub_pkg::ADDR_W-1:0] pick_addr;
	logic [LINE_W-1:0]         pick_wdata;

	// Fixed priority, display first
	always_comb begin
		pick_valid = 1'b1;
		pick_port  = hub_pkg::PORT_DISPLAY;
		pick_rw    = 1'b0;
		pick_addr  = disp_addr;
		pick_wdata = '0;
		if (disp_valid) begin
			pick_port = hub_pkg::PORT_DISPLAY;
		end else if (host_valid) begin
			pick_port  = hub_pkg::PORT_HOST;
			pick_rw    = host_rw;
			pick_addr  = host_addr;
			pick_wdata = host_wdata;
		end else if (test_valid) begin
			pick_port  = hub_pkg::PORT_TEST;
			pick_rw    = test_rw;
			pick_addr  = test_addr;
			pick_wdata = test_wdata;
		end else begin
			pick_valid = 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Command sequencer
	//////////////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			state_q <= hub_pkg::IDLE;
			grant_q <= hub_pkg::PORT_DISPLAY;
			rden_q  <= 1'b0;
		end else begin
			rden_q <= 1'b0;
			case (state_q)
				hub_pkg::IDLE: begin
					if (pick_valid) begin
						grant_q <= pick_port;
						if (pick_rw) begin
							state_q <= hub_pkg::WRITE;
						end else begin
							state_q <= hub_pkg::READ_WAIT;
							rden_q  <= 1'b1;
						end
					end
				end
				// Held here while the controller stalls
				hub_pkg::WRITE: begin
					if (mc_wr_rdy)
						state_q <= hub_pkg::DONE;
				end
				hub_pkg::READ_WAIT: begin
					if (mc_rd_valid)
						state_q <= hub_pkg::DONE;
				end
				default: begin
					state_q <= hub_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk_in) begin
		if (state_q == hub_pkg::IDLE) begin
			addr_q  <= pick_addr;
			wdata_q <= pick_wdata;
		end
		if (state_q == hub_pkg::READ_WAIT && mc_rd_valid)
			rdata_q <= data_rd;
	end

	assign data_wren = (state_q == hub_pkg::WRITE) && mc_wr_rdy;
	assign data_rden = rden_q;
	assign data_addr = addr_q;
	assign data_wr   = wdata_q;
	assign rdata     = rdata_q;

	// Ready only to the granted port
	assign disp_ready = (state_q == hub_pkg::DONE) && (grant_q == hub_pkg::PORT_DISPLAY);
	assign host_ready = (state_q == hub_pkg::DONE) && (grant_q == hub_pkg::PORT_HOST);
	assign test_ready = (state_q == hub_pkg::DONE) && (grant_q == hub_pkg::PORT_TEST);

endmodule

`default_nettype wire

/* design/mem_self_test.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_self_test #(
	parameter logic [hub_pkg::ADDR_W-1:0] TEST_BASE  = 28'h0100000,
	parameter int                         TEST_LINES = 16
) (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          test_ready,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] rdata,
	output logic                                          test_valid,
	output logic                                          test_rw,
	output logic [hub_pkg::ADDR_W-1:0]                    test_addr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] test_wdata,
	output logic                                          memory_read_error,
	output logic                                          test_done
);

	localparam int LINE_W = hub_pkg::LANE_W * hub_pkg::LINE_LANES;

	hub_pkg::test_state_e       state_q;
	logic [hub_pkg::ADDR_W-1:0] idx_q;
	logic                       error_q;
	logic                       last_idx;

	// Lane k of line a holds a*16 + k
	function automatic logic [LINE_W-1:0] pattern(input logic [hub_pkg::ADDR_W-1:0] addr);
		logic [LINE_W-1:0]         line;
		logic [hub_pkg::LANE_W-1:0] base;
		base = {addr, 4'h0};
		for (int k = 0; k < hub_pkg::LINE_LANES; k++) begin
			line[k*hub_pkg::LANE_W +: hub_pkg::LANE_W] = base + k;
		end
		return line;
	endfunction

	assign last_idx = (idx_q == hub_pkg::ADDR_W'(TEST_LINES - 1));

	always_ff @(posedge clk_in) begin
		if (gl_rst) begin
			state_q <= hub_pkg::FILL;
			idx_q   <= '0;
			error_q <= 1'b0;
		end else if (test_ready) begin
			// Sticky until the next reset
			if (state_q == hub_pkg::CHECK && rdata != pattern(test_addr))
				error_q <= 1'b1;
			if (last_idx) begin
				idx_q   <= '0;
				state_q <= (state_q == hub_pkg::FILL) ? hub_pkg::CHECK : hub_pkg::FINISHED;
			end else begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	// Request stays up, one line after another
	assign test_valid        = (state_q != hub_pkg::FINISHED);
	assign test_rw           = (state_q == hub_pkg::FILL);
	assign test_addr         = TEST_BASE + idx_q;
	assign test_wdata        = pattern(test_addr);
	assign memory_read_error = error_q;
	assign test_done         = (state_q == hub_pkg::FINISHED);

endmodule

`default_nettype wire

/* design/soc_mem_hub.sv */
`timescale 1ns/100ps
`default_nettype none

module soc_mem_hub #(
	parameter logic [hub_pkg::ADDR_W-1:0] TEST_BASE   = 28'h0100000,
	parameter int                         TEST_LINES  = 16,
	parameter int                         FRAME_LINES = 12
) (
	input  logic                                          clk_in,
	input  logic                                          gl_rst,
	input  logic                                          host_req,
	input  logic                                          host_rw,
	input  logic [hub_pkg::ADDR_W-1:0]                    host_addr,
	input  logic [hub_pkg::LANE_W-1:0]                    host_wdata,
	input  logic                                          mc_wr_rdy,
	input  logic                                          mc_rd_valid,
	input  logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_rd,
	output logic                                          host_done,
	output logic [hub_pkg::LANE_W-1:0]                    host_rdata,
	output logic                                          data_wren,
	output logic                                          data_rden,
	output logic [hub_pkg::ADDR_W-1:0]                    data_addr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] data_wr,
	output logic [hub_pkg::LANE_W*hub_pkg::LINE_LANES-1:0] line_data,
	output logic                                          line_valid,
	output logic                                          last_line,
	output logic                                          memory_read_error,
	output logic                                          test_done
);

	localparam int LINE_W = hub_pkg::LANE_W * hub_pkg::LINE_LANES;

	//////////////////////////////////////////////////
	// Requester wires
	//////////////////////////////////////////////////

	logic [LINE_W-1:0]          rdata;
	logic                       disp_valid;
	logic                       disp_ready;
	logic [hub_pkg::ADDR_W-1:0] disp_addr;
	logic                       host_valid;
	logic                       host_ready;
	logic                       host_mem_rw;
	logic [hub_pkg::ADDR_W-1:0] host_mem_addr;
	logic [LINE_W-1:0]          host_mem_wdata;
	logic                       test_valid;
	logic                       test_ready;
	logic                       test_rw;
	logic [hub_pkg::ADDR_W-1:0] test_addr;
	logic [LINE_W-1:0]          test_wdata;

	// Display control
	logic [hub_pkg::ADDR_W-1:0] mem_start;
	logic                       display_on;

	mem_arbiter i_mem_arbiter (
		.clk_in      (clk_in),
		.gl_rst      (gl_rst),
		.disp_valid  (disp_valid),
		.disp_addr   (disp_addr),
		.host_valid  (host_valid),
		.host_rw     (host_mem_rw),
		.host_addr   (host_mem_addr),
		.host_wdata  (host_mem_wdata),
		.test_valid  (test_valid),
		.test_rw     (test_rw),
		.test_addr   (test_addr),
		.test_wdata  (test_wdata),
		.mc_wr_rdy   (mc_wr_rdy),
		.mc_rd_valid (mc_rd_valid),
		.data_rd     (data_rd),
		.disp_ready  (disp_ready),
		.host_ready  (host_ready),
		.test_ready  (test_ready),
		.rdata       (rdata),
		.data_wren   (data_wren),
		.data_rden   (data_rden),
		.data_addr   (data_addr),
		.data_wr     (data_wr)
	);

	mem_self_test #(
		.TEST_BASE  (TEST_BASE),
		.TEST_LINES (TEST_LINES)
	) i_mem_self_test (
		.clk_in            (clk_in),
		.gl_rst            (gl_rst),
		.test_ready        (test_ready),
		.rdata             (rdata),
		.test_valid        (test_valid),
		.test_rw           (test_rw),
		.test_addr         (test_addr),
		.test_wdata        (test_wdata),
		.memory_read_error (memory_read_error),
		.test_done         (test_done)
	);

	display_fetch #(
		.FRAME_LINES (FRAME_LINES)
	) i_display_fetch (
		.clk_in     (clk_in),
		.gl_rst     (gl_rst),
		.display_on (display_on),
		.mem_start  (mem_start),
		.disp_ready (disp_ready),
		.rdata      (rdata),
		.disp_valid (disp_valid),
		.disp_addr  (disp_addr),
		.line_data  (line_data),
		.line_valid (line_valid),
		.last_line  (last_line)
	);

	io_map i_io_map (
		.clk_in            (clk_in),
		.gl_rst            (gl_rst),
		.host_req          (host_req),
		.host_rw           (host_rw),
		.host_addr         (host_addr),
		.host_wdata        (host_wdata),
		.host_ready        (host_ready),
		.rdata             (rdata),
		.memory_read_error (memory_read_error),
		.test_done         (test_done),
		.host_done         (host_done),
		.host_rdata        (host_rdata),
		.host_valid        (host_valid),
		.host_mem_rw       (host_mem_rw),
		.host_mem_addr     (host_mem_addr),
		.host_mem_wdata    (host_mem_wdata),
		.mem_start         (mem_start),
		.display_on        (display_on)
	);

endmodule

`default_nettype wire

/* src.f */
design/hub_pkg.sv
design/mem_arbiter.sv
design/mem_self_test.sv
design/display_fetch.sv
design/io_map.sv
design/soc_mem_hub.sv
bench/mem_ctrl_model.sv
bench/tb_soc_mem_hub.sv
